// ==== hw/resetn_synchronizer.sv ====
`timescale 1ns/1ns

module resetn_synchronizer (
    input  logic clk,
    input  logic rstn_async,
    output logic rstn_sync
);

    logic rstn_meta;

    // assertion is immediate, release waits for two rising edges
    always_ff @(posedge clk or negedge rstn_async) begin
        if (!rstn_async) begin
            rstn_meta <= 1'b0;
            rstn_sync <= 1'b0;
        end else begin
            rstn_meta <= 1'b1;
            rstn_sync <= rstn_meta;
        end
    end

endmodule

// ==== hw/systimer.sv ====
`timescale 1ns/1ns

module systimer #(
    parameter int SYNC_STAGES = 2
) (
    input  logic              clk_sys,
    input  logic              clk_32k,
    input  logic              rstn_sys,
    output timer_pkg::systime_t systime
);

    import timer_pkg::*;

    logic     rstn_32k_sync;
    logic     rstn_sys_sync;
    systime_t timer_gray;
    systime_t timer_bin;
    systime_t nxt_timer_gray;
    systime_t sync_gray [SYNC_STAGES];

    resetn_synchronizer u_rst_sync_32k (
        .clk        ( clk_32k       ),
        .rstn_async ( rstn_sys      ),
        .rstn_sync  ( rstn_32k_sync )
    );

    resetn_synchronizer u_rst_sync_sys (
        .clk        ( clk_sys       ),
        .rstn_async ( rstn_sys      ),
        .rstn_sync  ( rstn_sys_sync )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 32 kHz domain counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the count only lives in gray form, the increment goes through binary
    assign timer_bin      = gray_to_bin(timer_gray);
    assign nxt_timer_gray = bin_to_gray(timer_bin + 64'd1);

    always_ff @(posedge clk_32k or negedge rstn_32k_sync) begin
        if (!rstn_32k_sync) begin
            timer_gray <= '0;
        end else begin
            timer_gray <= nxt_timer_gray;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // crossing into the system domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one bit moves per tick, so the first stage settles to either the
    // old count or the new one
    always_ff @(posedge clk_sys or negedge rstn_sys_sync) begin
        if (!rstn_sys_sync) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_gray[i] <= '0;
            end
        end else begin
            sync_gray[0] <= timer_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_gray[i] <= sync_gray[i-1];
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rstn_sys_sync) begin
        if (!rstn_sys_sync) begin
            systime <= '0;
        end else begin
            systime <= gray_to_bin(sync_gray[SYNC_STAGES-1]);
        end
    end

endmodule

// ==== hw/timer_compare_unit.sv ====
`timescale 1ns/1ns

module timer_compare_unit (
    input  logic                 clk_sys,
    input  logic                 rstn_sys,
    input  timer_pkg::timer_op_t op,
    input  timer_pkg::systime_t  systime,
    output timer_pkg::timer_res_t res,
    output logic                 irq
);

    import timer_pkg::*;

    systime_t  cmp;
    logic      irq_en;
    logic      pending;
    reg_word_t time_hi_snap;
    logic      cmp_hit;
    logic      wr_en;
    logic      rd_en;
    logic      status_clr;
    logic      pending_d;
    logic      irq_en_d;
    reg_word_t rdata_d;

    assign wr_en   = op.valid && op.write && !op.err;
    assign rd_en   = op.valid && !op.write && !op.err;
    assign cmp_hit = (systime >= cmp);

    assign status_clr = wr_en && (op.sel == SEL_STATUS) && op.wdata[0];
    assign irq_en_d   = (wr_en && op.sel == SEL_CTRL) ? op.wdata[0] : irq_en;

    // the compare condition wins over a software clear in the same cycle
    assign pending_d = cmp_hit | (pending & ~status_clr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers and interrupt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_sys or negedge rstn_sys) begin
        if (!rstn_sys) begin
            cmp          <= '1;
            irq_en       <= 1'b0;
            pending      <= 1'b0;
            irq          <= 1'b0;
            time_hi_snap <= '0;
        end else begin
            if (wr_en && op.sel == SEL_CMP_LO) begin
                cmp[31:0] <= op.wdata;
            end
            if (wr_en && op.sel == SEL_CMP_HI) begin
                cmp[63:32] <= op.wdata;
            end
            // the high half is frozen so that a lo/hi read pair is coherent
            if (rd_en && op.sel == SEL_TIME_LO) begin
                time_hi_snap <= systime[63:32];
            end
            irq_en  <= irq_en_d;
            pending <= pending_d;
            irq     <= pending_d & irq_en_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rdata_d = '0;
        if (rd_en) begin
            case (op.sel)
                SEL_TIME_LO: rdata_d = systime[31:0];
                SEL_TIME_HI: rdata_d = time_hi_snap;
                SEL_CMP_LO:  rdata_d = cmp[31:0];
                SEL_CMP_HI:  rdata_d = cmp[63:32];
                SEL_CTRL:    rdata_d = {31'b0, irq_en};
                SEL_STATUS:  rdata_d = {31'b0, pending};
                default:     rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_sys or negedge rstn_sys) begin
        if (!rstn_sys) begin
            res <= '0;
        end else begin
            res.valid <= op.valid;
            res.rdata <= rdata_d;
            res.err   <= op.valid & op.err;
        end
    end

endmodule

// ==== hw/timer_pkg.sv ====
package timer_pkg;

    typedef logic [63:0] systime_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [4:0]  reg_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map, byte offsets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam reg_addr_t REG_TIME_LO = 5'h00;
    localparam reg_addr_t REG_TIME_HI = 5'h04;
    localparam reg_addr_t REG_CMP_LO  = 5'h08;
    localparam reg_addr_t REG_CMP_HI  = 5'h0C;
    localparam reg_addr_t REG_CTRL    = 5'h10;
    localparam reg_addr_t REG_STATUS  = 5'h14;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_TIME_LO,
        SEL_TIME_HI,
        SEL_CMP_LO,
        SEL_CMP_HI,
        SEL_CTRL,
        SEL_STATUS
    } reg_sel_e;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_word_t wdata;
    } timer_req_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        reg_sel_e  sel;
        reg_word_t wdata;
        logic      err;
    } timer_op_t;

    typedef struct packed {
        logic      valid;
        reg_word_t rdata;
        logic      err;
    } timer_res_t;

    typedef struct packed {
        reg_word_t rdata;
        logic      err;
    } timer_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // gray code conversion
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic systime_t bin_to_gray(input systime_t bin);
        systime_t gray;
        gray[63] = bin[63];
        for (int i = 62; i >= 0; i--) begin
            gray[i] = bin[i+1] ^ bin[i];
        end
        return gray;
    endfunction

    // each binary bit folds in every gray bit above it
    function automatic systime_t gray_to_bin(input systime_t gray);
        systime_t bin;
        bin[63] = gray[63];
        for (int i = 62; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// ==== hw/timer_reg_decode.sv ====
`timescale 1ns/1ns

module timer_reg_decode (
    input  logic                  clk_sys,
    input  logic                  rstn_sys,
    input  logic                  req_valid,
    input  timer_pkg::timer_req_t req,
    output timer_pkg::timer_op_t  op
);

    import timer_pkg::*;

    timer_op_t op_d;
    logic      addr_misaligned;

    assign addr_misaligned = |req.addr[1:0];

    always_comb begin
        op_d       = '0;
        op_d.valid = req_valid;
        op_d.write = req.write;
        op_d.wdata = req.wdata;
        op_d.sel   = SEL_NONE;

        if (addr_misaligned) begin
            op_d.err = req_valid;
        end else begin
            case (req.addr)
                REG_TIME_LO: op_d.sel = SEL_TIME_LO;
                REG_TIME_HI: op_d.sel = SEL_TIME_HI;
                REG_CMP_LO:  op_d.sel = SEL_CMP_LO;
                REG_CMP_HI:  op_d.sel = SEL_CMP_HI;
                REG_CTRL:    op_d.sel = SEL_CTRL;
                REG_STATUS:  op_d.sel = SEL_STATUS;
                default: begin
                    // aligned but outside the map
                    op_d.err = req_valid;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a new request may arrive every cycle, so this stage never stalls
    always_ff @(posedge clk_sys or negedge rstn_sys) begin
        if (!rstn_sys) begin
            op <= '0;
        end else begin
            op <= op_d;
        end
    end

endmodule

// ==== hw/timer_rsp_stage.sv ====
`timescale 1ns/1ns

module timer_rsp_stage (
    input  logic                  clk_sys,
    input  logic                  rstn_sys,
    input  timer_pkg::timer_res_t res,
    output logic                  rsp_valid,
    output timer_pkg::timer_rsp_t rsp
);

    import timer_pkg::*;

    timer_rsp_t rsp_d;

    assign rsp_d.rdata = res.rdata;
    assign rsp_d.err   = res.err;

    always_ff @(posedge clk_sys or negedge rstn_sys) begin
        if (!rstn_sys) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= res.valid;
        end
    end

    // payload only moves on a strobe and holds its value in between
    always_ff @(posedge clk_sys) begin
        if (res.valid) begin
            rsp <= rsp_d;
        end
    end

endmodule

// ==== hw/timer_subsys.sv ====
`timescale 1ns/1ns

module timer_subsys #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  clk_sys,
    input  logic                  clk_32k,
    input  logic                  rstn_sys,
    input  logic                  req_valid,
    input  timer_pkg::timer_req_t req,
    output logic                  rsp_valid,
    output timer_pkg::timer_rsp_t rsp,
    output logic                  irq,
    output timer_pkg::systime_t   systime
);

    import timer_pkg::*;

    logic       rstn_sys_sync;
    timer_op_t  op;
    timer_res_t res;

    resetn_synchronizer u_rst_sys (
        .clk        ( clk_sys       ),
        .rstn_async ( rstn_sys      ),
        .rstn_sync  ( rstn_sys_sync )
    );

    // the timer synchronizes its own resets for both clocks
    systimer #(
        .SYNC_STAGES ( SYNC_STAGES )
    ) u_systimer (
        .clk_sys  ( clk_sys  ),
        .clk_32k  ( clk_32k  ),
        .rstn_sys ( rstn_sys ),
        .systime  ( systime  )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register access pipeline, request to response in three cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    timer_reg_decode u_decode (
        .clk_sys   ( clk_sys       ),
        .rstn_sys  ( rstn_sys_sync ),
        .req_valid ( req_valid     ),
        .req       ( req           ),
        .op        ( op            )
    );

    timer_compare_unit u_execute (
        .clk_sys  ( clk_sys       ),
        .rstn_sys ( rstn_sys_sync ),
        .op       ( op            ),
        .systime  ( systime       ),
        .res      ( res           ),
        .irq      ( irq           )
    );

    timer_rsp_stage u_result (
        .clk_sys   ( clk_sys       ),
        .rstn_sys  ( rstn_sys_sync ),
        .res       ( res           ),
        .rsp_valid ( rsp_valid     ),
        .rsp       ( rsp           )
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module timer_subsys_tb \
    -f timer_subsys.f -o timer_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/timer_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^all tests passed$"; then
    exit 0
fi
exit 1

// ==== sim/timer_cases.txt ====
# columns: kind addr data expect, all hex
# kinds: K test, W write, X random write, R read, C masked readback, E error access,
# N wait, T time pair, S cmp = time + data, I wait for irq, L idle levels, Q/G burst
K 0 1 0
L 0 0 0
R 10 0 0
R 14 0 0
R 08 0 ffffffff
R 0c 0 ffffffff
K 0 2 0
X 08 0 0
C 08 ffffffff 0
X 0c 0 0
C 0c ffffffff 0
X 10 0 0
C 10 1 0
W 10 0 0
W 0c ffffffff 0
W 08 ffffffff 0
W 14 1 0
R 14 0 0
L 0 0 0
K 0 3 0
N 0 20 0
T 0 40 0
T 0 c8 0
K 0 4 0
S 0 a 0
W 10 1 0
I 0 64 1
R 14 0 1
W 0c ffffffff 0
W 08 ffffffff 0
W 14 1 0
L 0 0 0
R 14 0 0
K 0 5 0
W 10 0 0
S 0 5 0
N 0 40 0
R 14 0 1
L 0 0 0
W 0c ffffffff 0
W 08 ffffffff 0
W 14 1 0
E 18 0 0
E 02 0 0
E 18 1 0
Q 08 0 ffffffff
Q 10 0 0
Q 18 1 0
Q 14 0 0
Q 02 1 0
G 0 0 0

// ==== sim/timer_subsys_tb.sv ====
`timescale 1ns/1ns

module timer_subsys_tb;

    import timer_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic       clk_sys;
    logic       clk_32k;
    logic       rstn_sys;
    logic       req_valid;
    timer_req_t req;
    logic       rsp_valid;
    timer_rsp_t rsp;
    logic       irq;
    systime_t   systime;

    // one entry per case line
    logic [7:0]  c_kind [$];
    logic [63:0] c_addr [$];
    logic [63:0] c_data [$];
    logic [63:0] c_exp  [$];

    // requests of a burst and what came back, in order
    timer_req_t  q_req      [$];
    logic [63:0] q_rdata    [$];
    logic [63:0] q_err      [$];
    logic [63:0] q_exp_err  [$];
    logic [63:0] q_exp_data [$];

    logic [63:0] tick_count = '0;
    logic [63:0] wd_cycles  = '0;
    logic [63:0] cur_test   = '0;
    int          errors      = 0;
    int          checks      = 0;
    int          test_errors = 0;
    int          tests       = 0;
    int          bad_tests   = 0;

    timer_subsys #(
        .SYNC_STAGES ( 2 )
    ) timer_subsys_i (
        .clk_sys   ( clk_sys   ),
        .clk_32k   ( clk_32k   ),
        .rstn_sys  ( rstn_sys  ),
        .req_valid ( req_valid ),
        .req       ( req       ),
        .rsp_valid ( rsp_valid ),
        .rsp       ( rsp       ),
        .irq       ( irq       ),
        .systime   ( systime   )
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        clk_32k = 1'b0;
        forever #350 clk_32k = ~clk_32k;
    end

    always @(posedge clk_32k) begin
        tick_count <= tick_count + 64'd1;
    end

    initial begin
        wait (wd_cycles != 0);
        #(wd_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("tests failed");
        $finish;
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            count_error();
        end
    endtask

    task automatic load_cases();
        int          fd;
        string       line;
        logic [7:0]  kind;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] e;
        logic [63:0] wait_sum;
        wait_sum = '0;
        fd = $fopen("sim/timer_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file sim/timer_cases.txt");
            count_error();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%c %h %h %h", kind, a, d, e) == 4) begin
                        c_kind.push_back(kind);
                        c_addr.push_back(a);
                        c_data.push_back(d);
                        c_exp.push_back(e);
                        if (kind == "N" || kind == "I" || kind == "T") begin
                            wait_sum = wait_sum + d;
                        end
                    end else begin
                        $display("malformed case line: %s", line);
                        count_error();
                    end
                end
            end
            $fclose(fd);
        end
        wd_cycles = wait_sum + 64'(40 * c_kind.size()) + 64'd200;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // request k goes out at falling edge k and must be answered at edge k+3
    task automatic run_requests();
        int n;
        int sent;
        int got;
        int cyc;
        n    = q_req.size();
        sent = 0;
        got  = 0;
        cyc  = 0;
        while (got < n && cyc < n + 8) begin
            req_valid = (sent < n);
            if (sent < n) begin
                req = q_req[sent];
                sent++;
            end
            @(negedge clk_sys);
            cyc++;
            if (rsp_valid) begin
                check_value("rsp_valid latency", 64'(cyc), 64'(got + 3));
                q_rdata.push_back({32'd0, rsp.rdata});
                q_err.push_back({63'd0, rsp.err});
                got++;
            end
        end
        req_valid = 1'b0;
        if (got < n) begin
            $display("only %0d of %0d requests got a response", got, n);
            count_error();
        end else begin
            // the strobe must drop once the last response is in
            @(negedge clk_sys);
            check_value("rsp_valid", 64'(rsp_valid), 64'd0);
        end
        q_req.delete();
    endtask

    task automatic access(input logic wr, input logic [63:0] addr, input logic [63:0] wdata,
                          output logic [63:0] rdata, output logic [63:0] err);
        q_req.push_back('{write: wr, addr: addr[4:0], wdata: wdata[31:0]});
        run_requests();
        rdata = '0;
        err   = '1;
        if (q_rdata.size() != 0) begin
            rdata = q_rdata.pop_front();
            err   = q_err.pop_front();
        end
    endtask

    task automatic write_reg(input logic [63:0] addr, input logic [63:0] data);
        logic [63:0] rdata;
        logic [63:0] err;
        access(1'b1, addr, data, rdata, err);
        check_value("rsp.err", err, 64'd0);
    endtask

    task automatic read_reg(input logic [63:0] addr, output logic [63:0] rdata);
        logic [63:0] err;
        access(1'b0, addr, 64'd0, rdata, err);
        check_value("rsp.err", err, 64'd0);
    endtask

    // the systime port may only lead the snapshot by the ticks seen meanwhile
    task automatic read_time(output logic [63:0] t);
        logic [63:0] lo;
        logic [63:0] hi;
        logic [63:0] tick0;
        logic [63:0] port;
        tick0 = tick_count;
        read_reg(64'(REG_TIME_LO), lo);
        read_reg(64'(REG_TIME_HI), hi);
        port = systime;
        t    = {hi[31:0], lo[31:0]};
        check_value("systime not behind", 64'(port >= t), 64'd1);
        check_value("systime lead", 64'((port - t) <= (tick_count - tick0 + 64'd1)), 64'd1);
    endtask

    task automatic finish_test();
        if (tests != 0) begin
            $display("test %0d done with %0d errors", cur_test, test_errors);
            if (test_errors != 0) begin
                bad_tests++;
            end
        end
        test_errors = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // case sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] e;
        logic [63:0] rdata;
        logic [63:0] err;
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] tk1;
        logic [63:0] tk2;
        logic [63:0] cnt;
        logic [63:0] last_rand;
        void'($urandom(32'h9540));
        rstn_sys  = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        last_rand = '0;
        load_cases();
        repeat (5) @(negedge clk_sys);
        rstn_sys = 1'b1;
        repeat (4) @(negedge clk_sys);

        for (int i = 0; i < c_kind.size(); i++) begin
            a = c_addr[i];
            d = c_data[i];
            e = c_exp[i];
            case (c_kind[i])
                "K": begin
                    finish_test();
                    cur_test = d;
                    tests++;
                end
                "W": write_reg(a, d);
                "X": begin
                    last_rand = 64'($urandom());
                    write_reg(a, last_rand);
                end
                "R": begin
                    read_reg(a, rdata);
                    check_value("rsp.rdata", rdata, e);
                end
                "C": begin
                    read_reg(a, rdata);
                    check_value("rsp.rdata", rdata, last_rand & d);
                end
                "E": begin
                    access(d[0], a, 64'd0, rdata, err);
                    check_value("rsp.err", err, 64'd1);
                    check_value("rsp.rdata", rdata, 64'd0);
                end
                "N": repeat (d) @(negedge clk_sys);
                "T": begin
                    tk1 = tick_count;
                    read_time(t1);
                    repeat (d) @(negedge clk_sys);
                    tk2 = tick_count;
                    read_time(t2);
                    check_value("time not decreasing", 64'(t2 >= t1), 64'd1);
                    check_value("time step", 64'((t2 - t1) <= (tk2 - tk1 + 64'd1)), 64'd1);
                end
                "S": begin
                    read_time(t1);
                    t1 = t1 + d;
                    // high half parked at all ones so no partial value can hit
                    write_reg(64'(REG_CMP_HI), 64'hffff_ffff);
                    write_reg(64'(REG_CMP_LO), {32'd0, t1[31:0]});
                    write_reg(64'(REG_CMP_HI), {32'd0, t1[63:32]});
                end
                "I": begin
                    cnt = '0;
                    while (irq !== e[0] && cnt < d) begin
                        @(negedge clk_sys);
                        cnt = cnt + 64'd1;
                    end
                    if (irq !== e[0]) begin
                        $display("irq did not reach %0d within %0d cycles", e[0], d);
                        count_error();
                    end
                end
                "L": begin
                    check_value("irq", 64'(irq), e);
                    check_value("rsp_valid", 64'(rsp_valid), 64'd0);
                end
                "Q": begin
                    q_req.push_back('{write: 1'b0, addr: a[4:0], wdata: 32'd0});
                    q_exp_err.push_back(d);
                    q_exp_data.push_back(e);
                end
                "G": begin
                    run_requests();
                    for (int j = 0; j < q_rdata.size(); j++) begin
                        check_value("rsp.err", q_err[j], q_exp_err[j]);
                        check_value("rsp.rdata", q_rdata[j], q_exp_data[j]);
                    end
                    q_rdata.delete();
                    q_err.delete();
                    q_exp_err.delete();
                    q_exp_data.delete();
                end
                default: begin
                    $display("unknown case kind on case line %0d", i + 1);
                    count_error();
                end
            endcase
        end
        finish_test();

        $display("tests run: %0d, with errors: %0d, checks: %0d, errors: %0d",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== timer_subsys.f ====
hw/timer_pkg.sv
hw/resetn_synchronizer.sv
hw/systimer.sv
hw/timer_reg_decode.sv
hw/timer_compare_unit.sv
hw/timer_rsp_stage.sv
hw/timer_subsys.sv
sim/timer_subsys_tb.sv
